//--- rtl/ex_stage.sv
// EX stage with its control register, a six-operation ALU and the WB result register
`default_nettype none

`include "opnd_defines.svh"

module ex_stage (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     id_freeze,
	input  logic                     ex_freeze,
	// Control from ID
	input  opnd_data_pkg::reg_addr_t id_rd,
	input  opnd_ctrl_pkg::alu_op_t   id_alu_op,
	input  logic                     id_wr_en,
	// Registered operands
	input  opnd_data_pkg::word_t     operand_a,
	input  opnd_data_pkg::word_t     operand_b,
	// EX destination and result for forwarding
	output opnd_data_pkg::reg_addr_t ex_rd,
	output logic                     ex_wr_en,
	output opnd_data_pkg::word_t     ex_forw,
	// WB stage that also feeds the register file write port
	output logic                     wb_valid,
	output opnd_data_pkg::reg_addr_t wb_rd,
	output opnd_data_pkg::word_t     wb_data
);

	import opnd_data_pkg::*;
	import opnd_ctrl_pkg::*;

	// Op held in EX
	alu_op_t ex_alu_op;

	// Combinational ALU output
	word_t alu_result;

	//////////////////////////////////////////////////
	// EX control register
	//////////////////////////////////////////////////

	// EX frozen keeps the instruction
	// ID frozen alone inserts a bubble
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ex_rd     <= '0;
			ex_alu_op <= `OPND_ALU_ADD;
			ex_wr_en  <= 1'b0;
		end else if (!ex_freeze) begin
			if (id_freeze) begin
				ex_wr_en <= 1'b0;
			end else begin
				ex_rd     <= id_rd;
				ex_alu_op <= id_alu_op;
				ex_wr_en  <= id_wr_en;
			end
		end
	end

	//////////////////////////////////////////////////
	// ALU
	//////////////////////////////////////////////////

	// Add and subtract wrap at the word width
	always_comb begin
		case (ex_alu_op)
			`OPND_ALU_SUB:   alu_result = operand_a - operand_b;
			`OPND_ALU_AND:   alu_result = operand_a & operand_b;
			`OPND_ALU_OR:    alu_result = operand_a | operand_b;
			`OPND_ALU_XOR:   alu_result = operand_a ^ operand_b;
			`OPND_ALU_PASSB: alu_result = operand_b;
			// ADD and the two spare codes
			default:         alu_result = operand_a + operand_b;
		endcase
	end

	// Result forwards straight back to ID and is held with EX under freeze
	assign ex_forw = alu_result;

	//////////////////////////////////////////////////
	// WB register
	//////////////////////////////////////////////////

	// Valid strobe lasts one cycle per retiring instruction
	// Under EX freeze WB gets a bubble and keeps its old payload
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb_valid <= 1'b0;
			wb_rd    <= '0;
			wb_data  <= '0;
		end else if (ex_freeze) begin
			wb_valid <= 1'b0;
		end else begin
			wb_valid <= ex_wr_en;
			wb_rd    <= ex_rd;
			wb_data  <= alu_result;
		end
	end

endmodule

`default_nettype wire

//--- rtl/fwd_ctrl.sv
// Forwarding control that compares ID sources with EX and WB destinations to pick sources
`default_nettype none

`include "opnd_defines.svh"

module fwd_ctrl (
	// ID sources
	input  opnd_data_pkg::reg_addr_t ra,
	input  opnd_data_pkg::reg_addr_t rb,
	input  logic                     use_imm,
	// EX destination
	input  opnd_data_pkg::reg_addr_t ex_rd,
	input  logic                     ex_wr_en,
	// WB destination
	input  opnd_data_pkg::reg_addr_t wb_rd,
	input  logic                     wb_valid,
	// Operand source selects
	output opnd_ctrl_pkg::opnd_sel_t sel_a,
	output opnd_ctrl_pkg::opnd_sel_t sel_b
);

	import opnd_data_pkg::*;
	import opnd_ctrl_pkg::*;

	//////////////////////////////////////////////////
	// Hazard compare
	//////////////////////////////////////////////////

	// Source for one register operand
	// EX wins over WB and WB wins over the register file
	function automatic opnd_sel_t pick_src(input reg_addr_t src);
		logic ex_hit;
		logic wb_hit;
		opnd_sel_t sel;
		// A stage only matches when it writes
		ex_hit = ex_wr_en && (ex_rd == src);
		wb_hit = wb_valid && (wb_rd == src);
		if (ex_hit) begin
			sel = `OPND_SEL_EX_FORW;
		end else if (wb_hit) begin
			sel = `OPND_SEL_WB_FORW;
		end else begin
			sel = `OPND_SEL_RF;
		end
		return sel;
	endfunction

	//////////////////////////////////////////////////
	// Select outputs
	//////////////////////////////////////////////////

	always_comb begin
		// A is always a register operand
		sel_a = pick_src(ra);
		// Immediate on B overrides any hazard on rb
		if (use_imm) begin
			sel_b = `OPND_SEL_IMM;
		end else begin
			sel_b = pick_src(rb);
		end
	end

endmodule

`default_nettype wire

//--- rtl/operand_muxes.sv
// Operand select with source muxes for A and B and the freeze-aware EX operand registers
`default_nettype none

`include "opnd_defines.svh"

module operand_muxes (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     id_freeze,
	input  logic                     ex_freeze,
	// Candidate sources
	input  opnd_data_pkg::word_t     rf_data_a,
	input  opnd_data_pkg::word_t     rf_data_b,
	input  opnd_data_pkg::word_t     imm,
	input  opnd_data_pkg::word_t     ex_forw,
	input  opnd_data_pkg::word_t     wb_forw,
	// Selects from forwarding control
	input  opnd_ctrl_pkg::opnd_sel_t sel_a,
	input  opnd_ctrl_pkg::opnd_sel_t sel_b,
	// Registered EX operands
	output opnd_data_pkg::word_t     operand_a,
	output opnd_data_pkg::word_t     operand_b
);

	import opnd_data_pkg::*;

	// Mux outputs ahead of the operand registers
	word_t muxed_a;
	word_t muxed_b;

	// Set once an operand was captured under ID freeze
	logic saved_a;
	logic saved_b;

	//////////////////////////////////////////////////
	// Source muxes
	//////////////////////////////////////////////////

	// A has no immediate leg
	always_comb begin
		case (sel_a)
			`OPND_SEL_EX_FORW: muxed_a = ex_forw;
			`OPND_SEL_WB_FORW: muxed_a = wb_forw;
			default:           muxed_a = rf_data_a;
		endcase
	end

	always_comb begin
		case (sel_b)
			`OPND_SEL_IMM:     muxed_b = imm;
			`OPND_SEL_EX_FORW: muxed_b = ex_forw;
			`OPND_SEL_WB_FORW: muxed_b = wb_forw;
			default:           muxed_b = rf_data_b;
		endcase
	end

	//////////////////////////////////////////////////
	// Operand registers
	//////////////////////////////////////////////////

	// Hold everything while EX is frozen
	// First ID-frozen cycle captures and marks saved and later ones hold
	// Saved copy is consumed at the release edge and the flag clears
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			operand_a <= '0;
			saved_a   <= 1'b0;
		end else if (!ex_freeze) begin
			if (!saved_a) begin
				operand_a <= muxed_a;
				saved_a   <= id_freeze;
			end else if (!id_freeze) begin
				saved_a <= 1'b0;
			end
		end
	end

	// Same rule for B
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			operand_b <= '0;
			saved_b   <= 1'b0;
		end else if (!ex_freeze) begin
			if (!saved_b) begin
				operand_b <= muxed_b;
				saved_b   <= id_freeze;
			end else if (!id_freeze) begin
				saved_b <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/operand_pipe_top.sv
// Operand pipeline slice with ID register read and forwarding, EX ALU and WB write-back
`default_nettype none

`include "opnd_defines.svh"

module operand_pipe_top (
	input  logic                     clk,
	input  logic                     rst_n,
	// Freeze levels from outside the slice
	input  logic                     id_freeze,
	input  logic                     ex_freeze,
	// Decoded ID fields
	input  opnd_data_pkg::reg_addr_t id_ra,
	input  opnd_data_pkg::reg_addr_t id_rb,
	input  opnd_data_pkg::reg_addr_t id_rd,
	input  opnd_data_pkg::word_t     id_imm,
	input  logic                     id_use_imm,
	input  opnd_ctrl_pkg::alu_op_t   id_alu_op,
	input  logic                     id_wr_en,
	// Write-back
	output logic                     wb_valid,
	output opnd_data_pkg::reg_addr_t wb_rd,
	output opnd_data_pkg::word_t     wb_data
);

	import opnd_data_pkg::*;
	import opnd_ctrl_pkg::*;

	// ID read data
	word_t     rf_data_a;
	word_t     rf_data_b;
	// Operand selects
	opnd_sel_t sel_a;
	opnd_sel_t sel_b;
	// EX operands, destination and result
	word_t     operand_a;
	word_t     operand_b;
	reg_addr_t ex_rd;
	logic      ex_wr_en;
	word_t     ex_forw;

	//////////////////////////////////////////////////
	// ID stage
	//////////////////////////////////////////////////

	// Written from WB
	reg_file u_reg_file (
		.clk       (clk),
		.rst_n     (rst_n),
		.rd_addr_a (id_ra),
		.rd_addr_b (id_rb),
		.rd_data_a (rf_data_a),
		.rd_data_b (rf_data_b),
		.wr_en     (wb_valid),
		.wr_addr   (wb_rd),
		.wr_data   (wb_data)
	);

	fwd_ctrl u_fwd_ctrl (
		.ra       (id_ra),
		.rb       (id_rb),
		.use_imm  (id_use_imm),
		.ex_rd    (ex_rd),
		.ex_wr_en (ex_wr_en),
		.wb_rd    (wb_rd),
		.wb_valid (wb_valid),
		.sel_a    (sel_a),
		.sel_b    (sel_b)
	);

	// WB forward is the write-back data itself
	operand_muxes u_operand_muxes (
		.clk       (clk),
		.rst_n     (rst_n),
		.id_freeze (id_freeze),
		.ex_freeze (ex_freeze),
		.rf_data_a (rf_data_a),
		.rf_data_b (rf_data_b),
		.imm       (id_imm),
		.ex_forw   (ex_forw),
		.wb_forw   (wb_data),
		.sel_a     (sel_a),
		.sel_b     (sel_b),
		.operand_a (operand_a),
		.operand_b (operand_b)
	);

	//////////////////////////////////////////////////
	// EX and WB stages
	//////////////////////////////////////////////////

	ex_stage u_ex_stage (
		.clk       (clk),
		.rst_n     (rst_n),
		.id_freeze (id_freeze),
		.ex_freeze (ex_freeze),
		.id_rd     (id_rd),
		.id_alu_op (id_alu_op),
		.id_wr_en  (id_wr_en),
		.operand_a (operand_a),
		.operand_b (operand_b),
		.ex_rd     (ex_rd),
		.ex_wr_en  (ex_wr_en),
		.ex_forw   (ex_forw),
		.wb_valid  (wb_valid),
		.wb_rd     (wb_rd),
		.wb_data   (wb_data)
	);

endmodule

`default_nettype wire

//--- rtl/opnd_ctrl_pkg.sv
// Control types of the operand pipeline for operand source selects and ALU op codes
`default_nettype none

`include "opnd_defines.svh"

package opnd_ctrl_pkg;

	//////////////////////////////////////////////////
	// Control vectors
	//////////////////////////////////////////////////

	// Operand source select
	// Codes are OPND_SEL_RF, _IMM, _EX_FORW and _WB_FORW
	typedef logic [`OPND_SEL_W-1:0] opnd_sel_t;

	// ALU operation
	// Codes are the OPND_ALU_* macros
	typedef logic [`OPND_ALU_W-1:0] alu_op_t;

endpackage

`default_nettype wire

//--- rtl/opnd_data_pkg.sv
// Data-path types of the operand pipeline for data words and register indices
`default_nettype none

`include "opnd_defines.svh"

package opnd_data_pkg;

	//////////////////////////////////////////////////
	// Data path vectors
	//////////////////////////////////////////////////

	// One data word as it moves through ID, EX and WB
	typedef logic [`OPND_WIDTH-1:0] word_t;

	// Register index of a source or destination
	typedef logic [`OPND_REG_ADDR_W-1:0] reg_addr_t;

endpackage

`default_nettype wire

//--- rtl/opnd_defines.svh
// Operand pipeline constants for data widths, register count, select codes and ALU op codes
`ifndef OPND_DEFINES_SVH
`define OPND_DEFINES_SVH

// Data word and register index widths
`define OPND_WIDTH       32
`define OPND_REG_ADDR_W  4
`define OPND_REG_COUNT   (1 << `OPND_REG_ADDR_W)

// Operand source select codes
// Operand A never takes the immediate
`define OPND_SEL_W        2
`define OPND_SEL_RF       2'd0
`define OPND_SEL_IMM      2'd1
`define OPND_SEL_EX_FORW  2'd2
`define OPND_SEL_WB_FORW  2'd3

// ALU op codes where 6 and 7 fall back to ADD
`define OPND_ALU_W      3
`define OPND_ALU_ADD    3'd0
`define OPND_ALU_SUB    3'd1
`define OPND_ALU_AND    3'd2
`define OPND_ALU_OR     3'd3
`define OPND_ALU_XOR    3'd4
`define OPND_ALU_PASSB  3'd5

`endif

//--- rtl/reg_file.sv
// Register file of sixteen words with two combinational reads and one clocked write
`default_nettype none

`include "opnd_defines.svh"

module reg_file (
	input  logic                     clk,
	input  logic                     rst_n,
	// Read ports
	input  opnd_data_pkg::reg_addr_t rd_addr_a,
	input  opnd_data_pkg::reg_addr_t rd_addr_b,
	output opnd_data_pkg::word_t     rd_data_a,
	output opnd_data_pkg::word_t     rd_data_b,
	// Write port from WB
	input  logic                     wr_en,
	input  opnd_data_pkg::reg_addr_t wr_addr,
	input  opnd_data_pkg::word_t     wr_data
);

	import opnd_data_pkg::*;

	// Register storage
	word_t regs [`OPND_REG_COUNT];

	//////////////////////////////////////////////////
	// Write port
	//////////////////////////////////////////////////

	// Write lands at the edge that closes the WB cycle
	// All registers start from zero
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `OPND_REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wr_addr] <= wr_data;
		end
	end

	//////////////////////////////////////////////////
	// Read ports
	//////////////////////////////////////////////////

	// Plain asynchronous reads
	// Same-cycle write is covered by the WB forward path
	always_comb begin
		rd_data_a = regs[rd_addr_a];
		rd_data_b = regs[rd_addr_b];
	end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Build the operand pipeline testbench with Verilator, run it and check the result
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f tb.f --top-module operand_pipe_tb -o operand_pipe_sim

sim_output="$(./obj_dir/operand_pipe_sim)"
echo "$sim_output"

if grep -qx "Simulation PASSED" <<< "$sim_output"; then
	exit 0
fi
exit 1

//--- tb.f
+incdir+rtl
rtl/opnd_data_pkg.sv
rtl/opnd_ctrl_pkg.sv
rtl/reg_file.sv
rtl/fwd_ctrl.sv
rtl/operand_muxes.sv
rtl/ex_stage.sv
rtl/operand_pipe_top.sv
verif/operand_pipe_tb.sv

//--- verif/operand_pipe_tb.sv
// Testbench that drives the operand pipeline slice cycle by cycle from a stimulus trace
`default_nettype none

module operand_pipe_tb;

	import opnd_data_pkg::*;
	import opnd_ctrl_pkg::*;

	localparam int    CLK_PERIOD = 8;
	localparam string TRACE_FILE = "verif/operand_trace.txt";

	// One trace line with the ID inputs, freezes and expected write-back of that cycle
	typedef struct packed {
		int        test;
		reg_addr_t ra;
		reg_addr_t rb;
		reg_addr_t rd;
		word_t     imm;
		logic      use_imm;
		alu_op_t   alu_op;
		logic      wr_en;
		logic      id_freeze;
		logic      ex_freeze;
		logic      exp_valid;
		reg_addr_t exp_rd;
		word_t     exp_data;
	} trace_entry_t;

	// DUT inputs
	logic      clk;
	logic      rst_n;
	logic      id_freeze;
	logic      ex_freeze;
	reg_addr_t id_ra;
	reg_addr_t id_rb;
	reg_addr_t id_rd;
	word_t     id_imm;
	logic      id_use_imm;
	alu_op_t   id_alu_op;
	logic      id_wr_en;
	// DUT outputs
	logic      wb_valid;
	reg_addr_t wb_rd;
	word_t     wb_data;

	// Trace contents and bookkeeping
	trace_entry_t trace[$];
	logic         trace_loaded = 1'b0;
	int           cur_test;
	int           test_errors;
	int           total_errors;
	int           tests_passed;
	int           tests_failed;
	int           load_errors;

	operand_pipe_top u_dut (
		.clk        (clk),
		.rst_n      (rst_n),
		.id_freeze  (id_freeze),
		.ex_freeze  (ex_freeze),
		.id_ra      (id_ra),
		.id_rb      (id_rb),
		.id_rd      (id_rd),
		.id_imm     (id_imm),
		.id_use_imm (id_use_imm),
		.id_alu_op  (id_alu_op),
		.id_wr_en   (id_wr_en),
		.wb_valid   (wb_valid),
		.wb_rd      (wb_rd),
		.wb_data    (wb_data)
	);

	//////////////////////////////////////////////////
	// Clock and watchdog
	//////////////////////////////////////////////////

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Budget is one cycle per trace line plus slack for reset and drain
	initial begin
		wait (trace_loaded);
		#((trace.size() + 10) * CLK_PERIOD);
		$display("Timeout: the trace did not finish in the expected number of cycles");
		$display("Simulation FAILED");
		$finish;
	end

	//////////////////////////////////////////////////
	// Trace handling
	//////////////////////////////////////////////////

	// Skips comment and blank lines and needs all 13 columns on every other line
	task automatic load_trace();
		int        fd;
		int        got;
		string     line;
		int        test;
		reg_addr_t ra, rb, rd, exp_rd;
		word_t     imm, exp_data;
		alu_op_t   alu_op;
		logic      use_imm, wr_en, idf, exf, exp_valid;
		fd = $fopen(TRACE_FILE, "r");
		if (fd == 0) begin
			$display("Cannot open the trace file %s", TRACE_FILE);
			load_errors++;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				got = $fgets(line, fd);
				if (got > 0 && line.len() > 1 && line[0] != "#") begin
					got = $sscanf(line, "%d %h %h %h %h %h %h %h %h %h %h %h %h",
						test, ra, rb, rd, imm, use_imm, alu_op, wr_en,
						idf, exf, exp_valid, exp_rd, exp_data);
					if (got == 13) begin
						trace.push_back({test, ra, rb, rd, imm, use_imm, alu_op, wr_en,
							idf, exf, exp_valid, exp_rd, exp_data});
					end else begin
						$display("Trace line has missing or bad columns: %s", line);
						load_errors++;
					end
				end
			end
			$fclose(fd);
		end
		trace_loaded = 1'b1;
	endtask

	task automatic apply_inputs(input trace_entry_t e);
		id_ra      = e.ra;
		id_rb      = e.rb;
		id_rd      = e.rd;
		id_imm     = e.imm;
		id_use_imm = e.use_imm;
		id_alu_op  = e.alu_op;
		id_wr_en   = e.wr_en;
		id_freeze  = e.id_freeze;
		ex_freeze  = e.ex_freeze;
	endtask

	// Payload only matters while the strobe is expected
	task automatic check_outputs(input trace_entry_t e);
		if (wb_valid !== e.exp_valid) begin
			$display("FAILED at %0t: wb_valid expected %0b, got %0b",
				$time, e.exp_valid, wb_valid);
			test_errors++;
		end
		if (e.exp_valid) begin
			if (wb_rd !== e.exp_rd) begin
				$display("FAILED at %0t: wb_rd expected %0h, got %0h", $time, e.exp_rd, wb_rd);
				test_errors++;
			end
			if (wb_data !== e.exp_data) begin
				$display("FAILED at %0t: wb_data expected %08h, got %08h",
					$time, e.exp_data, wb_data);
				test_errors++;
			end
		end
	endtask

	task automatic close_test();
		if (test_errors == 0) begin
			$display("Test %0d passed", cur_test);
			tests_passed++;
		end else begin
			$display("Test %0d failed with %0d errors", cur_test, test_errors);
			tests_failed++;
		end
		total_errors += test_errors;
		test_errors = 0;
	endtask

	//////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////

	initial begin
		rst_n = 1'b0;
		apply_inputs('0);
		load_trace();
		if (trace.size() == 0) begin
			$display("No stimulus could be read from the trace file");
			$display("Simulation FAILED");
			$finish;
		end else begin
			repeat (3) @(posedge clk);
			#1;
			rst_n = 1'b1;
			cur_test = trace[0].test;
			// Drive just after the edge and compare just before the next one
			for (int idx = 0; idx < trace.size(); idx++) begin
				if (trace[idx].test != cur_test) begin
					close_test();
					cur_test = trace[idx].test;
				end
				apply_inputs(trace[idx]);
				#(CLK_PERIOD - 2);
				check_outputs(trace[idx]);
				@(posedge clk);
				#1;
			end
			close_test();
			$display("Tests passed %0d, failed %0d, errors %0d, trace errors %0d",
				tests_passed, tests_failed, total_errors, load_errors);
			if (tests_failed == 0 && load_errors == 0) begin
				$display("Simulation PASSED");
			end else begin
				$display("Simulation FAILED");
			end
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- verif/operand_trace.txt
# test ra rb rd imm use_imm alu_op wr_en id_freeze ex_freeze exp_wb_valid exp_wb_rd exp_wb_data
# test number in decimal, all other columns in hex, one line per clock cycle
1 0 0 1 11111111 1 5 1 0 0 0 0 00000000
1 0 0 2 a5a5f00f 1 5 1 0 0 0 0 00000000
1 0 0 0 00000000 0 0 0 0 0 1 1 11111111
1 0 0 0 00000000 0 0 0 0 0 1 2 a5a5f00f
1 1 2 4 00000000 0 0 1 0 0 0 0 00000000
2 4 1 5 00000000 0 4 1 0 0 0 0 00000000
2 1 5 6 00000000 0 2 1 0 0 1 4 b6b70120
2 0 0 0 00000000 0 0 0 0 0 1 5 a7a61031
3 6 1 7 00000000 0 1 1 0 0 1 6 01001011
3 0 0 8 00000100 1 5 1 0 0 0 0 00000000
3 0 0 8 00000200 1 5 1 0 0 1 7 efeeff00
3 8 7 9 00000000 0 0 1 0 0 1 8 00000100
4 2 0 a fffffff0 1 0 1 0 0 1 8 00000200
4 1 0 b 22222222 1 1 1 0 0 1 9 efef0100
4 2 0 c 0f0f0f0f 1 2 1 0 0 1 a a5a5efff
4 1 0 d 00ff00ff 1 3 1 0 0 1 b eeeeeeef
4 2 0 e ffffffff 1 4 1 0 0 1 c 0505000f
4 1 0 f 00000001 1 7 1 0 0 1 d 11ff11ff
5 0 0 3 0000abcd 1 5 1 0 0 1 e 5a5a0ff0
5 3 3 4 00000000 0 0 1 1 0 1 f 11111112
5 3 3 4 00000000 0 0 1 1 0 1 3 0000abcd
5 3 3 4 00000000 0 0 1 1 0 0 0 00000000
5 3 3 4 00000000 0 0 1 0 0 0 0 00000000
6 4 3 5 00000000 0 4 1 0 0 0 0 00000000
6 5 0 6 00000010 1 0 1 1 1 1 4 0001579a
6 5 0 6 00000010 1 0 1 1 0 0 0 00000000
6 5 0 6 00000010 1 0 1 0 0 1 5 0001fc57
6 0 0 0 00000000 0 0 0 0 0 0 0 00000000
6 0 0 0 00000000 0 0 0 0 0 1 6 0001fc67
